// ==== common/tcdm_ecc_cfg.svh ====
/* widths for the ECC-protected TCDM path; TCDM_DW must be a multiple of TCDM_CHUNK
   and TCDM_DEPTH must equal 2**TCDM_AW */
`ifndef TCDM_ECC_CFG_SVH
`define TCDM_ECC_CFG_SVH

`define TCDM_DW       64
`define TCDM_CHUNK    32
`define TCDM_NCHUNK   (`TCDM_DW / `TCDM_CHUNK)
`define TCDM_AW       8
`define TCDM_BW       (`TCDM_DW / 8)
`define TCDM_UW       2
`define TCDM_DEPTH    256

// hsiao check widths are clog2(k) + 2
`define TCDM_EW_DW    ($clog2(`TCDM_CHUNK) + 2)
`define TCDM_RQMETAW  (`TCDM_AW + 1 + `TCDM_BW + `TCDM_UW)
`define TCDM_EW_RQ    ($clog2(`TCDM_RQMETAW) + 2)
`define TCDM_RSMETAW  (1 + `TCDM_UW)
`define TCDM_EW_RS    ($clog2(`TCDM_RSMETAW) + 2)
`define TCDM_CWW      (`TCDM_CHUNK + `TCDM_EW_DW)                 // one stored chunk
`define TCDM_ECCW     (`TCDM_NCHUNK * `TCDM_EW_DW + `TCDM_EW_RQ) // request ecc field
`define TCDM_RECCW    (`TCDM_NCHUNK * `TCDM_EW_DW + `TCDM_EW_RS) // response ecc field

`endif

// ==== common/tcdm_ecc_pkg.sv ====
/* shared codeword and error types; hsiao_col supports check widths up to 16 bits */
`include "tcdm_ecc_cfg.svh"

package tcdm_ecc_pkg;

  typedef struct packed {
    logic [`TCDM_EW_DW-1:0] ecc;
    logic [`TCDM_CHUNK-1:0] data;
  } chunk_cw_t;

  // raw view for fault masking, field view for check and data
  typedef union packed {
    logic [`TCDM_CWW-1:0] raw;
    chunk_cw_t            f;
  } chunk_cw_u;

  typedef struct packed {
    logic multi;
    logic single; // bit 0
  } ecc_err_t;

  // idx-th odd-weight column of weight >= 3, in ascending weight then value
  function automatic logic [15:0] hsiao_col(input int unsigned idx, input int unsigned pw);
    int unsigned n;
    logic [15:0] col;
    n   = 0;
    col = '0;
    for (int unsigned w = 3; w <= pw; w += 2) begin
      for (int unsigned v = 0; v < (32'd1 << pw); v++) begin
        if ($countones(v) == w) begin
          if (n == idx) col = v[15:0];
          n++;
        end
      end
    end
    return col;
  endfunction

endpackage

// ==== common/tcdm_ecc_if.sv ====
/* TCDM request/response with ECC; no r_ready, the target always answers one cycle
   after a transfer */
`timescale 1ns/10ps
`include "tcdm_ecc_cfg.svh"

interface tcdm_ecc_if;

  // request
  logic                   req;
  logic                   gnt;
  logic [`TCDM_AW-1:0]    add;
  logic                   wen;  // 1 = read
  logic [`TCDM_DW-1:0]    data;
  logic [`TCDM_BW-1:0]    be;
  logic [`TCDM_UW-1:0]    user;
  logic [`TCDM_ECCW-1:0]  ecc;  // data checks above metadata checks

  // response
  logic                   r_valid;
  logic [`TCDM_DW-1:0]    r_data;
  logic                   r_opc;  // 1 = dropped on metadata error
  logic [`TCDM_UW-1:0]    r_user;
  logic [`TCDM_RECCW-1:0] r_ecc;

  modport initiator (
    output req, add, wen, data, be, user, ecc,
    input  gnt, r_valid, r_data, r_opc, r_user, r_ecc
  );

  modport target (
    input  req, add, wen, data, be, user, ecc,
    output gnt, r_valid, r_data, r_opc, r_user, r_ecc
  );

endinterface

// ==== hw/hsiao_enc.sv ====
/* SEC-DED encoder, cw_o = {check, data}; prot_width must offer data_width odd-weight
   columns of weight 3 or more */
`timescale 1ns/10ps

module hsiao_enc #(
  parameter int unsigned data_width = 32,
  parameter int unsigned prot_width = 7
) (
  input  logic [data_width-1:0]            data_i,
  output logic [data_width+prot_width-1:0] cw_o
);

  logic [data_width-1:0][prot_width-1:0] contrib;
  logic [prot_width-1:0]                 chk;

  for (genvar i = 0; i < data_width; i++) begin : g_col
    localparam logic [prot_width-1:0] col =
      prot_width'(tcdm_ecc_pkg::hsiao_col(i, prot_width));
    assign contrib[i] = {prot_width{data_i[i]}} & col;
  end

  always_comb begin
    chk = '0;
    for (int i = 0; i < data_width; i++) begin
      chk ^= contrib[i];
    end
  end

  assign cw_o = {chk, data_i};

endmodule

// ==== hw/hsiao_dec.sv ====
/* SEC-DED decoder for the hsiao_enc code with cw_i = {check, data}; a corrupted check
   bit is flagged as single but data_o is unaffected */
`timescale 1ns/10ps

module hsiao_dec #(
  parameter int unsigned data_width = 32,
  parameter int unsigned prot_width = 7
) (
  input  logic [data_width+prot_width-1:0] cw_i,
  output logic [data_width-1:0]            data_o,
  output tcdm_ecc_pkg::ecc_err_t           err_o
);

  logic [data_width-1:0]                 data_in;
  logic [prot_width-1:0]                 chk_in;
  logic [data_width-1:0][prot_width-1:0] contrib;
  logic [prot_width-1:0]                 syndrome;
  logic [data_width-1:0]                 hit;
  logic                                  chk_hit;

  assign {chk_in, data_in} = cw_i;

  for (genvar i = 0; i < data_width; i++) begin : g_col
    localparam logic [prot_width-1:0] col =
      prot_width'(tcdm_ecc_pkg::hsiao_col(i, prot_width));
    assign contrib[i] = {prot_width{data_in[i]}} & col;
    assign hit[i]     = (syndrome == col);  // syndrome points at this data bit
  end

  always_comb begin
    syndrome = chk_in;
    for (int i = 0; i < data_width; i++) begin
      syndrome ^= contrib[i];
    end
  end

  assign chk_hit = ($countones(syndrome) == 1); // flip in a check bit

  assign data_o       = data_in ^ hit;
  assign err_o.single = (|hit) | chk_hit;
  assign err_o.multi  = (syndrome != '0) & ~err_o.single;

  // distinct columns mean a syndrome names at most one data bit
  always_comb begin : p_err_excl
    assert ($onehot0(hit))
      else $error("hsiao_dec: more than one data column matches the syndrome");
  end

endmodule

// ==== hw/ecc_bridge/ecc_bridge.sv ====
/* core-side ECC bridge; encodes data chunks and request metadata, decodes the
   response. The error outputs are meaningful only while r_valid_o is high */
`timescale 1ns/10ps
`include "tcdm_ecc_cfg.svh"

module ecc_bridge (
  input  logic                      req_i,
  input  logic [`TCDM_AW-1:0]       add_i,
  input  logic                      wen_i,
  input  logic [`TCDM_DW-1:0]       data_i,
  input  logic [`TCDM_BW-1:0]       be_i,
  input  logic [`TCDM_UW-1:0]       user_i,
  output logic                      gnt_o,
  output logic                      r_valid_o,
  output logic [`TCDM_DW-1:0]       r_data_o,
  output logic                      r_opc_o,
  output logic [`TCDM_UW-1:0]       r_user_o,
  output logic [`TCDM_NCHUNK-1:0]   r_data_single_err_o,
  output logic [`TCDM_NCHUNK-1:0]   r_data_multi_err_o,
  output logic                      r_meta_single_err_o,
  output logic                      r_meta_multi_err_o,
  tcdm_ecc_if.initiator             mem
);

  tcdm_ecc_pkg::chunk_cw_t [`TCDM_NCHUNK-1:0] data_cw;
  tcdm_ecc_pkg::ecc_err_t  [`TCDM_NCHUNK-1:0] data_err;
  tcdm_ecc_pkg::ecc_err_t                     meta_err;
  logic [`TCDM_RQMETAW+`TCDM_EW_RQ-1:0]       meta_cw;
  logic [`TCDM_RSMETAW-1:0]                   r_meta_fix;

  // request side
  for (genvar ii = 0; ii < `TCDM_NCHUNK; ii++) begin : g_chunk
    hsiao_enc #(
      .data_width ( `TCDM_CHUNK ),
      .prot_width ( `TCDM_EW_DW )
    ) i_data_enc (
      .data_i ( data_i[ii*`TCDM_CHUNK +: `TCDM_CHUNK] ),
      .cw_o   ( data_cw[ii]                           )
    );

    assign mem.data[ii*`TCDM_CHUNK +: `TCDM_CHUNK]              = data_cw[ii].data;
    assign mem.ecc[`TCDM_EW_RQ + ii*`TCDM_EW_DW +: `TCDM_EW_DW] = data_cw[ii].ecc;

    // response side, one decoder per chunk
    hsiao_dec #(
      .data_width ( `TCDM_CHUNK ),
      .prot_width ( `TCDM_EW_DW )
    ) i_data_dec (
      .cw_i   ( {mem.r_ecc[`TCDM_EW_RS + ii*`TCDM_EW_DW +: `TCDM_EW_DW],
                 mem.r_data[ii*`TCDM_CHUNK +: `TCDM_CHUNK]} ),
      .data_o ( r_data_o[ii*`TCDM_CHUNK +: `TCDM_CHUNK]     ),
      .err_o  ( data_err[ii]                                )
    );

    assign r_data_single_err_o[ii] = data_err[ii].single;
    assign r_data_multi_err_o[ii]  = data_err[ii].multi;
  end

  hsiao_enc #(
    .data_width ( `TCDM_RQMETAW ),
    .prot_width ( `TCDM_EW_RQ   )
  ) i_meta_enc (
    .data_i ( {add_i, wen_i, be_i, user_i} ),
    .cw_o   ( meta_cw                      )
  );

  assign {mem.add, mem.wen, mem.be, mem.user} = meta_cw[`TCDM_RQMETAW-1:0];
  assign mem.ecc[`TCDM_EW_RQ-1:0]             = meta_cw[`TCDM_RQMETAW +: `TCDM_EW_RQ];

  // r_opc / r_user
  hsiao_dec #(
    .data_width ( `TCDM_RSMETAW ),
    .prot_width ( `TCDM_EW_RS   )
  ) i_meta_dec (
    .cw_i   ( {mem.r_ecc[`TCDM_EW_RS-1:0], mem.r_opc, mem.r_user} ),
    .data_o ( r_meta_fix                                        ),
    .err_o  ( meta_err                                          )
  );

  assign {r_opc_o, r_user_o} = r_meta_fix;
  assign r_meta_single_err_o = meta_err.single;
  assign r_meta_multi_err_o  = meta_err.multi;

  // plain strobes pass straight through
  assign mem.req   = req_i;
  assign gnt_o     = mem.gnt;
  assign r_valid_o = mem.r_valid;

endmodule

// ==== hw/ecc_bank/bank_req_check.sv ====
/* decode stage; grants every request at once and cancels an access whose metadata
   carries an uncorrectable error */
`timescale 1ns/10ps
`include "tcdm_ecc_cfg.svh"

module bank_req_check (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  tcdm_ecc_if.target             bus,
  output logic                   we_o,
  output logic                   re_o,
  output logic [`TCDM_AW-1:0]    add_o,
  output logic [`TCDM_BW-1:0]    be_o,
  output logic [`TCDM_UW-1:0]    user_o,
  output logic                   drop_o,
  output tcdm_ecc_pkg::ecc_err_t meta_err_o
);

  logic [`TCDM_RQMETAW-1:0] meta_fix;
  logic                     wen_fix;

  hsiao_dec #(
    .data_width ( `TCDM_RQMETAW ),
    .prot_width ( `TCDM_EW_RQ   )
  ) i_meta_dec (
    .cw_i   ( {bus.ecc[`TCDM_EW_RQ-1:0], bus.add, bus.wen, bus.be, bus.user} ),
    .data_o ( meta_fix                                                  ),
    .err_o  ( meta_err_o                                                )
  );

  assign {add_o, wen_fix, be_o, user_o} = meta_fix; // corrected fields

  assign bus.gnt = bus.req;  // single port so nothing to arbitrate
  assign drop_o  = bus.req & meta_err_o.multi;
  assign we_o    = bus.req & ~wen_fix & ~meta_err_o.multi;
  assign re_o    = bus.req &  wen_fix & ~meta_err_o.multi;

  a_clean_pass : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (bus.req && !meta_err_o.single && !meta_err_o.multi) |->
      (add_o == bus.add && be_o == bus.be && user_o == bus.user && re_o == bus.wen))
    else $error("bank_req_check: clean request metadata changed by the decoder");

endmodule

// ==== hw/ecc_bank/bank_array.sv ====
/* execute stage; stores chunk codewords as received, flip_mask_i is XORed in on a
   write. Unwritten words read back undefined */
`timescale 1ns/10ps
`include "tcdm_ecc_cfg.svh"

module bank_array (
  input  logic                                       clk_i,
  input  logic                                       we_i,
  input  logic                                       re_i,
  input  logic [`TCDM_AW-1:0]                        add_i,
  input  logic [`TCDM_BW-1:0]                        be_i,
  input  tcdm_ecc_pkg::chunk_cw_t [`TCDM_NCHUNK-1:0] wdata_i,
  input  logic [`TCDM_NCHUNK-1:0][`TCDM_CWW-1:0]     flip_mask_i,
  output tcdm_ecc_pkg::chunk_cw_t [`TCDM_NCHUNK-1:0] rcw_o
);

  localparam int unsigned chunk_bw = `TCDM_BW / `TCDM_NCHUNK;  // byte enables per chunk

  for (genvar ii = 0; ii < `TCDM_NCHUNK; ii++) begin : g_chunk
    tcdm_ecc_pkg::chunk_cw_u mem_q [`TCDM_DEPTH];
    tcdm_ecc_pkg::chunk_cw_u wr_cw;
    tcdm_ecc_pkg::chunk_cw_t rd_q;
    logic                    chunk_we;

    // any enabled byte writes the whole codeword, check bits included
    assign chunk_we  = we_i & (|be_i[ii*chunk_bw +: chunk_bw]);
    assign wr_cw.raw = wdata_i[ii] ^ flip_mask_i[ii];  // fault injection

    always_ff @(posedge clk_i) begin
      if (chunk_we) begin
        mem_q[add_i] <= wr_cw;
      end
      if (re_i) begin
        rd_q <= mem_q[add_i].f;
      end
    end

    assign rcw_o[ii] = rd_q;
  end

endmodule

// ==== hw/ecc_bank/bank_rsp_enc.sv ====
/* result stage; one r_valid pulse per transfer, r_data and its checks are zero
   unless the transfer was an accepted read */
`timescale 1ns/10ps
`include "tcdm_ecc_cfg.svh"

module bank_rsp_enc (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  input  logic                                       xfer_i,
  input  logic                                       drop_i,
  input  logic                                       read_i,
  input  logic [`TCDM_UW-1:0]                        user_i,
  input  tcdm_ecc_pkg::chunk_cw_t [`TCDM_NCHUNK-1:0] rcw_i,
  tcdm_ecc_if.target                                 bus
);

  logic                                 valid_q;
  logic                                 drop_q;
  logic                                 read_q;
  logic [`TCDM_UW-1:0]                  user_q;
  logic [`TCDM_RSMETAW+`TCDM_EW_RS-1:0] rs_cw;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      drop_q  <= 1'b0;
      read_q  <= 1'b0;
      user_q  <= '0;
    end else begin
      valid_q <= xfer_i;
      drop_q  <= drop_i;
      read_q  <= read_i;  // lines up with the array read data
      user_q  <= user_i;
    end
  end

  hsiao_enc #(
    .data_width ( `TCDM_RSMETAW ),
    .prot_width ( `TCDM_EW_RS   )
  ) i_rsp_enc (
    .data_i ( {drop_q, user_q} ),
    .cw_o   ( rs_cw            )
  );

  assign bus.r_valid                = valid_q;
  assign {bus.r_opc, bus.r_user}    = rs_cw[`TCDM_RSMETAW-1:0];
  assign bus.r_ecc[`TCDM_EW_RS-1:0] = rs_cw[`TCDM_RSMETAW +: `TCDM_EW_RS];

  // all-zero chunk is a valid codeword, so writes decode clean
  for (genvar ii = 0; ii < `TCDM_NCHUNK; ii++) begin : g_chunk
    assign bus.r_data[ii*`TCDM_CHUNK +: `TCDM_CHUNK] = read_q ? rcw_i[ii].data : '0;
    assign bus.r_ecc[`TCDM_EW_RS + ii*`TCDM_EW_DW +: `TCDM_EW_DW] =
      read_q ? rcw_i[ii].ecc : '0;
  end

  a_drop_rsp : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    drop_i |=> (bus.r_valid && bus.r_opc && (bus.r_data == '0)))
    else $error("bank_rsp_enc: dropped request not answered with r_opc set");

endmodule

// ==== hw/tcdm_ecc_top.sv ====
/* ECC bridge and single-port bank joined by one TCDM link; keep flip_mask_i at zero
   outside of self-test writes */
`timescale 1ns/10ps
`include "tcdm_ecc_cfg.svh"

module tcdm_ecc_top (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  logic                                   req_i,
  input  logic [`TCDM_AW-1:0]                    add_i,
  input  logic                                   wen_i,
  input  logic [`TCDM_DW-1:0]                    data_i,
  input  logic [`TCDM_BW-1:0]                    be_i,
  input  logic [`TCDM_UW-1:0]                    user_i,
  output logic                                   gnt_o,
  output logic                                   r_valid_o,
  output logic [`TCDM_DW-1:0]                    r_data_o,
  output logic                                   r_opc_o,
  output logic [`TCDM_UW-1:0]                    r_user_o,
  output logic [`TCDM_NCHUNK-1:0]                r_data_single_err_o,
  output logic [`TCDM_NCHUNK-1:0]                r_data_multi_err_o,
  output logic                                   r_meta_single_err_o,
  output logic                                   r_meta_multi_err_o,
  output logic                                   bank_meta_single_err_o,
  output logic                                   bank_meta_multi_err_o,
  input  logic [`TCDM_NCHUNK-1:0][`TCDM_CWW-1:0] flip_mask_i
);

  tcdm_ecc_if bus ();

  logic                                       we;
  logic                                       re;
  logic [`TCDM_AW-1:0]                        add;
  logic [`TCDM_BW-1:0]                        be;
  logic [`TCDM_UW-1:0]                        user;
  logic                                       drop;
  logic                                       xfer;
  tcdm_ecc_pkg::ecc_err_t                     meta_err;
  tcdm_ecc_pkg::chunk_cw_t [`TCDM_NCHUNK-1:0] wcw;
  tcdm_ecc_pkg::chunk_cw_t [`TCDM_NCHUNK-1:0] rcw;

  ecc_bridge i_ecc_bridge (
    .req_i, .add_i, .wen_i, .data_i, .be_i, .user_i,
    .gnt_o, .r_valid_o, .r_data_o, .r_opc_o, .r_user_o,
    .r_data_single_err_o, .r_data_multi_err_o,
    .r_meta_single_err_o, .r_meta_multi_err_o,
    .mem ( bus.initiator )
  );

  bank_req_check i_bank_req_check (
    .clk_i, .arst_n_i,
    .bus        ( bus.target ),
    .we_o       ( we         ),
    .re_o       ( re         ),
    .add_o      ( add        ),
    .be_o       ( be         ),
    .user_o     ( user       ),
    .drop_o     ( drop       ),
    .meta_err_o ( meta_err   )
  );

  // write codewords straight off the bus
  for (genvar ii = 0; ii < `TCDM_NCHUNK; ii++) begin : g_wcw
    assign wcw[ii].data = bus.data[ii*`TCDM_CHUNK +: `TCDM_CHUNK];
    assign wcw[ii].ecc  = bus.ecc[`TCDM_EW_RQ + ii*`TCDM_EW_DW +: `TCDM_EW_DW];
  end

  bank_array i_bank_array (
    .clk_i,
    .we_i        ( we          ),
    .re_i        ( re          ),
    .add_i       ( add         ),
    .be_i        ( be          ),
    .wdata_i     ( wcw         ),
    .flip_mask_i ( flip_mask_i ),
    .rcw_o       ( rcw         )
  );

  assign xfer = bus.req & bus.gnt;

  bank_rsp_enc i_bank_rsp_enc (
    .clk_i, .arst_n_i,
    .xfer_i ( xfer       ),
    .drop_i ( drop       ),
    .read_i ( re         ),
    .user_i ( user       ),
    .rcw_i  ( rcw        ),
    .bus    ( bus.target )
  );

  assign bank_meta_single_err_o = meta_err.single;
  assign bank_meta_multi_err_o  = meta_err.multi;

endmodule

// ==== tb/tb_tcdm_ecc.sv ====
/* directed tests of the ECC TCDM path; reads only addresses that a test wrote first */
`timescale 1ns/10ps
`include "tcdm_ecc_cfg.svh"

module tb_tcdm_ecc;

  localparam int unsigned rsp_timeout = 20;  // cycles
  localparam int unsigned chunk_bytes = `TCDM_BW / `TCDM_NCHUNK;

  logic                                   clk, arst_n, req, wen;
  logic [`TCDM_AW-1:0]                    add;
  logic [`TCDM_DW-1:0]                    wdata;
  logic [`TCDM_BW-1:0]                    be;
  logic [`TCDM_UW-1:0]                    user;
  logic [`TCDM_NCHUNK-1:0][`TCDM_CWW-1:0] flip_mask;
  logic                                   gnt, r_valid, r_opc;
  logic [`TCDM_DW-1:0]                    r_data;
  logic [`TCDM_UW-1:0]                    r_user;
  logic [`TCDM_NCHUNK-1:0]                r_single, r_multi;
  logic                                   r_meta_single, r_meta_multi;
  logic                                   bank_single, bank_multi;

  // response as seen in the r_valid cycle
  logic [`TCDM_DW-1:0]     rsp_data;
  logic                    rsp_opc, rsp_meta_single, rsp_meta_multi;
  logic [`TCDM_UW-1:0]     rsp_user;
  logic [`TCDM_NCHUNK-1:0] rsp_single, rsp_multi;

  logic [`TCDM_DW-1:0] model_mem [`TCDM_DEPTH];
  logic [`TCDM_AW-1:0] used_q [$];  // addresses with a defined model value

  tcdm_ecc_top i_tcdm_ecc_top (
    .clk_i (clk), .arst_n_i (arst_n),
    .req_i (req), .add_i (add), .wen_i (wen), .data_i (wdata), .be_i (be), .user_i (user),
    .gnt_o (gnt), .r_valid_o (r_valid), .r_data_o (r_data), .r_opc_o (r_opc),
    .r_user_o (r_user),
    .r_data_single_err_o (r_single), .r_data_multi_err_o (r_multi),
    .r_meta_single_err_o (r_meta_single), .r_meta_multi_err_o (r_meta_multi),
    .bank_meta_single_err_o (bank_single), .bank_meta_multi_err_o (bank_multi),
    .flip_mask_i (flip_mask)
  );

  always #50 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input logic [63:0] act, input logic [63:0] exp, input string what);
    if (act !== exp) begin
      abort_run($sformatf("mismatch at %0t ns: %s, got %h expected %h", $time, what, act, exp));
    end
  endtask

  function automatic logic [`TCDM_AW-1:0] rand_addr();
    logic [31:0] r;
    r = $urandom;
    return r[`TCDM_AW-1:0];
  endfunction

  function automatic logic [`TCDM_UW-1:0] rand_user();
    logic [31:0] r;
    r = $urandom;
    return r[`TCDM_UW-1:0];
  endfunction

  // one request and then a wait for its response pulse
  task automatic do_req(input logic rd, input logic [`TCDM_AW-1:0] a,
                        input logic [`TCDM_DW-1:0] d, input logic [`TCDM_BW-1:0] b,
                        input logic [`TCDM_UW-1:0] u,
                        input logic [`TCDM_NCHUNK-1:0][`TCDM_CWW-1:0] m);
    int unsigned waited;
    @(posedge clk);
    #1;
    req       = 1'b1;
    wen       = rd;
    add       = a;
    wdata     = d;
    be        = b;
    user      = u;
    flip_mask = m;
    @(negedge clk);
    check_eq(64'(gnt), 64'd1, "gnt_o in request cycle");
    check_eq(64'(bank_single), 64'd0, "bank metadata single error");
    check_eq(64'(bank_multi), 64'd0, "bank metadata multi error");
    @(posedge clk);
    #1;
    req       = 1'b0;
    flip_mask = '0;
    waited    = 0;
    @(negedge clk);
    while (r_valid !== 1'b1) begin
      if (waited >= rsp_timeout) abort_run("timeout, no r_valid_o after a request");
      waited++;
      @(negedge clk);
    end
    check_eq(64'(waited), 64'd0, "r_valid_o latency");
    rsp_data        = r_data;
    rsp_opc         = r_opc;
    rsp_user        = r_user;
    rsp_single      = r_single;
    rsp_multi       = r_multi;
    rsp_meta_single = r_meta_single;
    rsp_meta_multi  = r_meta_multi;
    if (!rd) check_eq(rsp_data, 64'd0, "write response data");
    @(negedge clk);
    check_eq(64'(r_valid), 64'd0, "r_valid_o is a single pulse");
  endtask

  task automatic write_word(input logic [`TCDM_AW-1:0] a, input logic [`TCDM_DW-1:0] d,
                            input logic [`TCDM_NCHUNK-1:0][`TCDM_CWW-1:0] m);
    do_req(1'b0, a, d, '1, rand_user(), m);
    model_mem[a] = d;
    used_q.push_back(a);
  endtask

  task automatic check_clean(input string what);
    check_eq(64'(rsp_opc), 64'd0, {what, ": r_opc_o"});
    check_eq(64'(rsp_single), 64'd0, {what, ": data single flags"});
    check_eq(64'(rsp_multi), 64'd0, {what, ": data multi flags"});
    check_eq(64'(rsp_meta_single), 64'd0, {what, ": response metadata single"});
    check_eq(64'(rsp_meta_multi), 64'd0, {what, ": response metadata multi"});
  endtask

  task automatic test_write_read();
    logic [`TCDM_AW-1:0] a;
    logic [`TCDM_UW-1:0] u;
    for (int i = 0; i < 16; i++) begin
      a = rand_addr();
      u = rand_user();
      write_word(a, {$urandom, $urandom}, '0);
      do_req(1'b1, a, '0, '1, u, '0);
      check_eq(rsp_data, model_mem[a], "read back data");
      check_eq(64'(rsp_user), 64'(u), "read back r_user_o");
      check_clean("read back");
    end
  endtask

  // reads back to back with a gap, so one response overlaps the next request
  task automatic test_timing();
    logic                pat_req;
    logic [`TCDM_AW-1:0] pat_addr;
    logic                prev_req;
    logic [`TCDM_AW-1:0] prev_addr;
    prev_req  = 1'b0;
    prev_addr = '0;
    for (int i = 0; i < 10; i++) begin
      pat_req  = (i != 4) && (i != 9);  // last slot idle drains the pipe
      pat_addr = used_q[$urandom_range(used_q.size() - 1, 0)];
      @(posedge clk);
      #1;
      req  = pat_req;
      wen  = 1'b1;
      add  = pat_addr;
      be   = '1;
      user = '0;
      @(negedge clk);
      check_eq(64'(gnt), 64'(pat_req), "gnt_o follows req_i");
      check_eq(64'(r_valid), 64'(prev_req), "r_valid_o one cycle after request");
      if (prev_req) check_eq(r_data, model_mem[prev_addr], "back to back read data");
      prev_req  = pat_req;
      prev_addr = pat_addr;
    end
  endtask

  task automatic test_flip(input bit two_bits);
    logic [`TCDM_AW-1:0]                    a;
    logic [`TCDM_NCHUNK-1:0][`TCDM_CWW-1:0] m;
    logic [`TCDM_NCHUNK-1:0]                hit;
    int                                     c, p1, p2;
    for (int i = 0; i < 6; i++) begin
      a      = rand_addr();
      c      = $urandom_range(`TCDM_NCHUNK - 1, 0);
      p1     = $urandom_range(`TCDM_CWW - 1, 0);
      p2     = (p1 + 1 + $urandom_range(`TCDM_CWW - 2, 0)) % `TCDM_CWW;  // never p1
      m      = '0;
      m[c][p1] = 1'b1;
      if (two_bits) m[c][p2] = 1'b1;
      hit    = '0;
      hit[c] = 1'b1;
      write_word(a, {$urandom, $urandom}, m);
      do_req(1'b1, a, '0, '1, '0, '0);
      for (int k = 0; k < `TCDM_NCHUNK; k++) begin
        if (k != c || !two_bits) begin
          check_eq(64'(rsp_data[k*`TCDM_CHUNK +: `TCDM_CHUNK]),
                   64'(model_mem[a][k*`TCDM_CHUNK +: `TCDM_CHUNK]), "corrected chunk data");
        end
      end
      check_eq(64'(rsp_single), two_bits ? 64'd0 : 64'(hit), "single flags after injection");
      check_eq(64'(rsp_multi), two_bits ? 64'(hit) : 64'd0, "multi flags after injection");
      check_eq(64'(rsp_meta_single | rsp_meta_multi), 64'd0, "metadata flags after injection");
      write_word(a, model_mem[a], '0);  // leave the word clean
    end
  endtask

  task automatic test_byte_enables();
    logic [`TCDM_AW-1:0] a;
    logic [`TCDM_DW-1:0] d;
    logic [`TCDM_BW-1:0] b;
    for (int i = 0; i < 4; i++) begin
      a = used_q[$urandom_range(used_q.size() - 1, 0)];
      d = {$urandom, $urandom};
      b = (i % 2 == 0) ? 8'hf0 : 8'h0f;  // one whole chunk at a time
      do_req(1'b0, a, d, b, '0, '0);
      for (int k = 0; k < `TCDM_NCHUNK; k++) begin
        if (|b[k*chunk_bytes +: chunk_bytes]) begin
          model_mem[a][k*`TCDM_CHUNK +: `TCDM_CHUNK] = d[k*`TCDM_CHUNK +: `TCDM_CHUNK];
        end
      end
      do_req(1'b1, a, '0, '1, '0, '0);
      check_eq(rsp_data, model_mem[a], "data after chunk write");
      check_clean("chunk write");
    end
  endtask

  task automatic test_response_user();
    logic [`TCDM_AW-1:0] a;
    for (int u = 0; u < (1 << `TCDM_UW); u++) begin
      a = used_q[$urandom_range(used_q.size() - 1, 0)];
      do_req(1'b1, a, '0, '1, u[`TCDM_UW-1:0], '0);
      check_eq(64'(rsp_user), 64'(u), "r_user_o");
      check_eq(rsp_data, model_mem[a], "data with user bits");
      check_clean("response user");
    end
  endtask

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    req       = 1'b0;
    wen       = 1'b1;
    add       = '0;
    wdata     = '0;
    be        = '0;
    user      = '0;
    flip_mask = '0;
    void'($urandom(51));
    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    check_eq(64'(r_valid), 64'd0, "r_valid_o low after reset");
    test_write_read();
    test_timing();
    test_flip(1'b0);
    test_flip(1'b1);
    test_byte_enables();
    test_response_user();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+common
common/tcdm_ecc_pkg.sv
common/tcdm_ecc_if.sv
hw/hsiao_enc.sv
hw/hsiao_dec.sv
hw/ecc_bridge/ecc_bridge.sv
hw/ecc_bank/bank_req_check.sv
hw/ecc_bank/bank_array.sv
hw/ecc_bank/bank_rsp_enc.sv
hw/tcdm_ecc_top.sv
tb/tb_tcdm_ecc.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_tcdm_ecc
RTL_TOP   ?= tcdm_ecc_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/10ps

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
